// File: hdl/backend_pkg.sv
package backend_pkg;

    // ======================================================================
    // basic types
    // ======================================================================
    typedef logic [31:0] xlen_t;    // one data word

    // alu operations, shifts use rs2[4:0]
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // signed compare
        ALU_SLTU,   // unsigned compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA     // arithmetic right shift
    } alu_op_e;

    // load/store kind, nine codes so four bits are needed
    typedef enum logic [3:0] {
        DMEM_NONE,
        DMEM_LB,
        DMEM_LH,
        DMEM_LW,
        DMEM_LBU,
        DMEM_LHU,
        DMEM_SB,
        DMEM_SH,
        DMEM_SW
    } dmem_type_e;

    // one-hot write-back source
    typedef logic [3:0] result_src_t;

    localparam int RES_ALU_BIT  = 0;    // alu result
    localparam int RES_LOAD_BIT = 1;    // load data
    localparam int RES_IMM_BIT  = 2;    // extended imm, lui
    localparam int RES_PC4_BIT  = 3;    // pc+4, jal

    // ======================================================================
    // data memory sizing
    // ======================================================================
    localparam int DMEM_DEPTH = 256;                    // words
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);     // word address bits
    localparam int DMEM_WAIT  = 2;                      // wait states, must be >= 1
    localparam int WAIT_CW    = $clog2(DMEM_WAIT + 1);  // counter holds DMEM_WAIT

    // ======================================================================
    // stage records
    // ======================================================================
    typedef struct packed {
        logic        valid;
        alu_op_e     alu_op;
        xlen_t       rs1;
        xlen_t       rs2;
        xlen_t       store_data;
        xlen_t       extended_imm;
        xlen_t       pc_plus4;
        dmem_type_e  dmem_type;
        logic        reg_write_en;
        logic [4:0]  rd_idx;
        result_src_t result_src;
        logic        instr_illegal;
    } id_exe_t;

    typedef struct packed {
        logic        valid;
        xlen_t       alu_result;    // also the memory address
        xlen_t       store_data;
        xlen_t       extended_imm;
        xlen_t       pc_plus4;
        dmem_type_e  dmem_type;
        logic        reg_write_en;
        logic [4:0]  rd_idx;
        result_src_t result_src;
        logic        instr_illegal;
    } exe_mem_t;

    typedef struct packed {
        logic        valid;
        xlen_t       alu_result;
        xlen_t       load_data;     // already extended
        xlen_t       extended_imm;
        xlen_t       pc_plus4;
        logic        reg_write_en;
        logic [4:0]  rd_idx;
        result_src_t result_src;
        logic        instr_illegal;
    } mem_wb_t;

endpackage

// File: hdl/exe_stage.sv
module exe_stage
    import backend_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     stall_i,   // memory stage busy, hold everything
    input  id_exe_t  id_i,
    output exe_mem_t exe_o
);

    // ======================================================================
    // alu
    // ======================================================================
    xlen_t      alu_res;
    logic [4:0] shamt;

    assign shamt = id_i.rs2[4:0];   // only low 5 bits count

    always_comb begin
        case (id_i.alu_op)
            ALU_ADD:  alu_res = id_i.rs1 + id_i.rs2;
            ALU_SUB:  alu_res = id_i.rs1 - id_i.rs2;
            ALU_AND:  alu_res = id_i.rs1 & id_i.rs2;
            ALU_OR:   alu_res = id_i.rs1 | id_i.rs2;
            ALU_XOR:  alu_res = id_i.rs1 ^ id_i.rs2;
            ALU_SLT: begin
                alu_res = {31'b0, $signed(id_i.rs1) < $signed(id_i.rs2)};
            end
            ALU_SLTU: begin
                alu_res = {31'b0, id_i.rs1 < id_i.rs2};
            end
            ALU_SLL:  alu_res = id_i.rs1 << shamt;
            ALU_SRL:  alu_res = id_i.rs1 >> shamt;
            ALU_SRA:  alu_res = xlen_t'($signed(id_i.rs1) >>> shamt);
            default:  alu_res = '0;  // unused codes
        endcase
    end

    // ======================================================================
    // execute to memory register
    // ======================================================================

    // valid bit, the only control state here
    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_o.valid <= 1'b0;
        end else if (!stall_i) begin
            exe_o.valid <= id_i.valid;
        end
    end

    // payload, frozen while the memory stage works on it
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            exe_o.alu_result    <= alu_res;
            exe_o.store_data    <= id_i.store_data;
            exe_o.extended_imm  <= id_i.extended_imm;
            exe_o.pc_plus4      <= id_i.pc_plus4;
            exe_o.dmem_type     <= id_i.dmem_type;
            exe_o.reg_write_en  <= id_i.reg_write_en;
            exe_o.rd_idx        <= id_i.rd_idx;
            exe_o.result_src    <= id_i.result_src;
            exe_o.instr_illegal <= id_i.instr_illegal;
        end
    end

endmodule

// File: hdl/wait_timer.sv
module wait_timer
    import backend_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic start_i,   // begin one access window
    output logic done_o     // last wait cycle
);

    logic [WAIT_CW-1:0] cnt_q;
    logic               busy;

    assign busy = (cnt_q != '0);

    // load on start, then count down to zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (start_i && !busy) begin
            cnt_q <= WAIT_CW'(DMEM_WAIT);
        end else if (busy) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // high in the cycle where the count drops to zero,
    // which is DMEM_WAIT cycles after the start cycle
    assign done_o = (cnt_q == WAIT_CW'(1));

endmodule

// File: hdl/mem_access_fsm.sv
module mem_access_fsm
    import backend_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  exe_mem_t   exe_i,
    // wait-state timer
    input  logic       timer_done_i,
    output logic       timer_start_o,
    // data ram request
    output logic       req_o,
    output logic       we_o,
    output xlen_t      addr_o,
    output xlen_t      wdata_o,
    output dmem_type_e dmem_type_o,
    input  xlen_t      rdata_i,
    // pipeline control and result
    output logic       stall_o,
    output mem_wb_t    wb_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,    // timer running
        ST_ACCESS   // ram request this cycle
    } state_e;

    state_e state_q, state_d;
    logic   is_mem;
    logic   is_store;
    logic   wb_valid_d;

    assign is_mem   = exe_i.valid && (exe_i.dmem_type != DMEM_NONE);
    assign is_store = exe_i.dmem_type inside {DMEM_SB, DMEM_SH, DMEM_SW};

    // ======================================================================
    // control
    // ======================================================================
    always_comb begin
        state_d    = state_q;
        wb_valid_d = 1'b0;  // bubble unless stated
        case (state_q)
            ST_IDLE: begin
                if (is_mem) begin
                    state_d = ST_WAIT;
                end else begin
                    wb_valid_d = exe_i.valid;   // plain pass-through
                end
            end
            ST_WAIT: begin
                if (timer_done_i) state_d = ST_ACCESS;
            end
            ST_ACCESS: begin
                state_d    = ST_IDLE;
                wb_valid_d = 1'b1;  // load or store retires here
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q  <= ST_IDLE;
            wb_o.valid <= 1'b0;
        end else begin
            state_q  <= state_d;
            wb_o.valid <= wb_valid_d;
        end
    end

    assign timer_start_o = (state_q == ST_IDLE) && is_mem;
    // low in ACCESS so execute takes the next entry at the access edge
    assign stall_o       = is_mem && (state_q != ST_ACCESS);

    // ram side, address comes straight from the alu
    assign req_o       = (state_q == ST_ACCESS);
    assign we_o        = req_o && is_store;
    assign addr_o      = exe_i.alu_result;
    assign wdata_o     = exe_i.store_data;
    assign dmem_type_o = exe_i.dmem_type;

    // ======================================================================
    // memory to write-back payload, meaningless when valid is low
    // ======================================================================
    always_ff @(posedge clk) begin
        wb_o.alu_result    <= exe_i.alu_result;
        wb_o.load_data     <= rdata_i;  // extended by the ram
        wb_o.extended_imm  <= exe_i.extended_imm;
        wb_o.pc_plus4      <= exe_i.pc_plus4;
        wb_o.reg_write_en  <= exe_i.reg_write_en;
        wb_o.rd_idx        <= exe_i.rd_idx;
        wb_o.result_src    <= exe_i.result_src;
        wb_o.instr_illegal <= exe_i.instr_illegal;
    end

endmodule

// File: hdl/dmem_ram.sv
module dmem_ram
    import backend_pkg::*;
(
    input  logic       clk,
    input  logic       req_i,
    input  logic       we_i,
    input  xlen_t      addr_i,      // byte address
    input  xlen_t      wdata_i,
    input  dmem_type_e dmem_type_i,
    output xlen_t      rdata_o      // extended load data
);

    xlen_t mem [DMEM_DEPTH];

    logic [DMEM_AW-1:0] waddr;
    logic [1:0]         boff;
    logic [3:0]         be;
    xlen_t              wlane;
    xlen_t              rword;
    logic [7:0]         rbyte;
    logic [15:0]        rhalf;

    assign waddr = addr_i[DMEM_AW+1:2];
    assign boff  = addr_i[1:0];

    // ======================================================================
    // store path
    // ======================================================================
    always_comb begin
        be    = 4'b0000;
        wlane = wdata_i;
        case (dmem_type_i)
            DMEM_SB: begin
                be    = 4'b0001 << boff;
                wlane = {4{wdata_i[7:0]}};
            end
            DMEM_SH: begin
                be    = boff[1] ? 4'b1100 : 4'b0011;   // aligned lane only
                wlane = {2{wdata_i[15:0]}};
            end
            DMEM_SW: be = 4'b1111;
            default: be = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) mem[waddr][b*8 +: 8] <= wlane[b*8 +: 8];
            end
        end
    end

    // ======================================================================
    // load path, combinational
    // ======================================================================
    assign rword = mem[waddr];
    assign rbyte = rword[boff*8 +: 8];
    assign rhalf = boff[1] ? rword[31:16] : rword[15:0];

    always_comb begin
        case (dmem_type_i)
            DMEM_LB:  rdata_o = {{24{rbyte[7]}}, rbyte};
            DMEM_LBU: rdata_o = {24'b0, rbyte};
            DMEM_LH:  rdata_o = {{16{rhalf[15]}}, rhalf};
            DMEM_LHU: rdata_o = {16'b0, rhalf};
            DMEM_LW:  rdata_o = rword;
            default:  rdata_o = '0;  // stores and none
        endcase
    end

endmodule

// File: hdl/wb_stage.sv
module wb_stage
    import backend_pkg::*;
(
    input  mem_wb_t    wb_i,
    output logic       rf_we_o,
    output logic [4:0] rf_waddr_o,
    output xlen_t      rf_wdata_o,
    output logic       illegal_o
);

    // one-hot and-or select of the result
    assign rf_wdata_o = ({32{wb_i.result_src[RES_ALU_BIT]}}  & wb_i.alu_result)
                      | ({32{wb_i.result_src[RES_LOAD_BIT]}} & wb_i.load_data)
                      | ({32{wb_i.result_src[RES_IMM_BIT]}}  & wb_i.extended_imm)
                      | ({32{wb_i.result_src[RES_PC4_BIT]}}  & wb_i.pc_plus4);

    assign rf_waddr_o = wb_i.rd_idx;

    // x0 stays zero, illegal entries never write
    assign rf_we_o = wb_i.valid
                  && wb_i.reg_write_en
                  && !wb_i.instr_illegal
                  && (wb_i.rd_idx != 5'd0);

    assign illegal_o = wb_i.valid && wb_i.instr_illegal;  // one cycle per entry

endmodule

// File: hdl/backend_top.sv
module backend_top
    import backend_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  id_exe_t    id_i,        // from decode, held while stalled
    output logic       stall_o,
    output logic       rf_we_o,
    output logic [4:0] rf_waddr_o,
    output xlen_t      rf_wdata_o,
    output logic       illegal_o
);

    exe_mem_t   exe_q;
    mem_wb_t    wb_q;
    logic       timer_start;
    logic       timer_done;
    logic       dmem_req;
    logic       dmem_we;
    xlen_t      dmem_addr;
    xlen_t      dmem_wdata;
    xlen_t      dmem_rdata;
    dmem_type_e dmem_type;

    // ======================================================================
    // stages
    // ======================================================================
    exe_stage u_exe (
        .clk     (clk),
        .resetn  (resetn),
        .stall_i (stall_o),
        .id_i    (id_i),
        .exe_o   (exe_q)
    );

    mem_access_fsm u_mem (
        .clk           (clk),
        .resetn        (resetn),
        .exe_i         (exe_q),
        .timer_done_i  (timer_done),
        .timer_start_o (timer_start),
        .req_o         (dmem_req),
        .we_o          (dmem_we),
        .addr_o        (dmem_addr),
        .wdata_o       (dmem_wdata),
        .dmem_type_o   (dmem_type),
        .rdata_i       (dmem_rdata),
        .stall_o       (stall_o),
        .wb_o          (wb_q)
    );

    wait_timer u_timer (
        .clk     (clk),
        .resetn  (resetn),
        .start_i (timer_start),
        .done_o  (timer_done)
    );

    dmem_ram u_dmem (
        .clk         (clk),
        .req_i       (dmem_req),
        .we_i        (dmem_we),
        .addr_i      (dmem_addr),
        .wdata_i     (dmem_wdata),
        .dmem_type_i (dmem_type),
        .rdata_o     (dmem_rdata)
    );

    wb_stage u_wb (
        .wb_i       (wb_q),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o),
        .illegal_o  (illegal_o)
    );

endmodule

// File: verif/backend_checker.sv
module backend_checker
    import backend_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input logic       stall_i,
    input logic       rf_we_i,
    input logic [4:0] rf_waddr_i,
    input logic       illegal_i
);

    int         assert_errors = 0;  // read by the testbench
    logic       reset_seen_q;       // reset low at the previous edge
    logic [7:0] stall_run_q;        // consecutive stalled edges

    always_ff @(posedge clk) begin
        reset_seen_q <= !resetn;
    end

    always_ff @(posedge clk) begin
        if (!resetn || !stall_i) stall_run_q <= '0;
        else if (stall_run_q != 8'hff) stall_run_q <= stall_run_q + 1'b1;
    end

    // ======================================================================
    // properties
    // ======================================================================
    reset_quiet: assert property (@(posedge clk)
        reset_seen_q |-> (!stall_i && !rf_we_i && !illegal_i))
        else begin
            $error("outputs active while in reset");
            assert_errors++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!resetn)
        rf_we_i |-> (rf_waddr_i != 5'd0))
        else begin
            $error("register write aimed at x0");
            assert_errors++;
        end

    stall_bounded: assert property (@(posedge clk) disable iff (!resetn)
        stall_run_q <= DMEM_WAIT + 2)
        else begin
            $error("stall held too long");
            assert_errors++;
        end

endmodule

bind backend_top backend_checker u_chk (
    .clk        (clk),
    .resetn     (resetn),
    .stall_i    (stall_o),
    .rf_we_i    (rf_we_o),
    .rf_waddr_i (rf_waddr_o),
    .illegal_i  (illegal_o)
);

// File: verif/tb_backend_top.sv
module tb_backend_top
    import backend_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 400;                // mixed random instructions
    localparam int MEM_WORDS  = 32;                 // words touched by loads and stores
    localparam int N_TOTAL    = MEM_WORDS + N_RANDOM;
    localparam int WATCHDOG   = N_TOTAL * (DMEM_WAIT + 4) * CLK_PERIOD + 200 * CLK_PERIOD;

    typedef struct packed {
        logic [4:0] rd;
        xlen_t      data;
    } rf_write_t;

    logic       clk;
    logic       resetn;
    id_exe_t    id_i;
    logic       stall_o;
    logic       rf_we_o;
    logic [4:0] rf_waddr_o;
    xlen_t      rf_wdata_o;
    logic       illegal_o;

    integer     seed;
    int         error_count;
    int         writes_checked;
    int         illegal_exp;    // illegal entries sent
    int         illegal_seen;   // illegal_o pulses counted
    rf_write_t  exp_q[$];       // expected writes, program order
    logic [7:0] mem_model [DMEM_DEPTH*4];

    backend_top uut (
        .clk        (clk),
        .resetn     (resetn),
        .id_i       (id_i),
        .stall_o    (stall_o),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o),
        .rf_wdata_o (rf_wdata_o),
        .illegal_o  (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic xlen_t alu_model(alu_op_e op, xlen_t a, xlen_t b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return sa >>> b[4:0];    // sign fills from the left
            default:  return '0;
        endcase
    endfunction

    // little-endian bytes, addresses already aligned
    function automatic xlen_t load_model(dmem_type_e t, int addr);
        case (t)
            DMEM_LB:  return {{24{mem_model[addr][7]}}, mem_model[addr]};
            DMEM_LBU: return {24'b0, mem_model[addr]};
            DMEM_LH:  return {{16{mem_model[addr+1][7]}}, mem_model[addr+1], mem_model[addr]};
            DMEM_LHU: return {16'b0, mem_model[addr+1], mem_model[addr]};
            default:  return {mem_model[addr+3], mem_model[addr+2],
                              mem_model[addr+1], mem_model[addr]};
        endcase
    endfunction

    task automatic store_model(input dmem_type_e t, input int addr, input xlen_t data);
        case (t)
            DMEM_SB: mem_model[addr] = data[7:0];
            DMEM_SH: begin
                mem_model[addr]   = data[7:0];
                mem_model[addr+1] = data[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) mem_model[addr+b] = data[b*8 +: 8];
            end
        endcase
    endtask

    // expected effect of one accepted instruction
    task automatic predict(input id_exe_t ins);
        rf_write_t w;
        xlen_t     addr;
        if (!ins.valid) return;     // bubble
        addr = ins.rs1 + ins.rs2;   // effective address from the adder
        if (ins.instr_illegal) illegal_exp++;
        w.rd = ins.rd_idx;
        if (ins.result_src[RES_LOAD_BIT]) w.data = load_model(ins.dmem_type, int'(addr));
        else if (ins.result_src[RES_IMM_BIT]) w.data = ins.extended_imm;
        else if (ins.result_src[RES_PC4_BIT]) w.data = ins.pc_plus4;
        else w.data = alu_model(ins.alu_op, ins.rs1, ins.rs2);
        if (ins.dmem_type inside {DMEM_SB, DMEM_SH, DMEM_SW}) begin
            store_model(ins.dmem_type, int'(addr), ins.store_data);
        end
        if (ins.reg_write_en && !ins.instr_illegal && ins.rd_idx != 5'd0) exp_q.push_back(w);
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic make_instr(output id_exe_t ins);
        int    pick;
        int    addr;
        xlen_t off;
        pick = $unsigned($random(seed)) % 16;
        ins = '0;
        ins.valid        = 1'b1;
        ins.alu_op       = alu_op_e'($unsigned($random(seed)) % 10);
        ins.rs1          = $random(seed);
        ins.rs2          = $random(seed);
        ins.extended_imm = $random(seed);
        ins.pc_plus4     = $random(seed);
        ins.rd_idx       = 5'($random(seed));
        ins.reg_write_en = ($unsigned($random(seed)) % 8) != 0;   // mostly writing
        ins.result_src   = 4'b0001;
        ins.dmem_type    = DMEM_NONE;
        if (pick < 6) begin
            ins.instr_illegal = ($unsigned($random(seed)) % 8) == 0;
        end else if (pick < 8) begin
            ins.result_src = (pick == 6) ? 4'b0100 : 4'b1000;   // lui or jal
        end else begin
            ins.dmem_type = dmem_type_e'(1 + $unsigned($random(seed)) % 8);
            addr = $unsigned($random(seed)) % (MEM_WORDS * 4);
            if (ins.dmem_type inside {DMEM_LH, DMEM_LHU, DMEM_SH}) addr = addr & ~1;
            if (ins.dmem_type inside {DMEM_LW, DMEM_SW}) addr = addr & ~3;
            off            = $unsigned($random(seed)) % 64;
            ins.alu_op     = ALU_ADD;
            ins.rs2        = off;
            ins.rs1        = addr - off;   // base plus offset lands on addr
            ins.store_data = $random(seed);
            if (ins.dmem_type inside {DMEM_SB, DMEM_SH, DMEM_SW}) ins.reg_write_en = 1'b0;
            else ins.result_src = 4'b0010;
        end
    endtask

    // present on a falling edge once the pipeline is free to take it
    task automatic send_instr(input id_exe_t ins);
        @(negedge clk);
        while (stall_o) @(negedge clk);
        id_i = ins;
        predict(ins);
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR: time %0t signal %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // write port monitor, pre-edge values
    always @(posedge clk) begin : write_monitor
        rf_write_t exp_w;
        if (rf_we_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("unexpected register write to x%0d at time %0t", rf_waddr_o, $time);
            end else begin
                exp_w = exp_q.pop_front();
                check_value("rf_waddr_o", rf_waddr_o, exp_w.rd);
                check_value("rf_wdata_o", rf_wdata_o, exp_w.data);
                writes_checked++;
            end
        end
        if (illegal_o === 1'b1) illegal_seen++;
    end

    initial begin : main
        id_exe_t ins;
        seed           = 32'he708;
        error_count    = 0;
        writes_checked = 0;
        illegal_exp    = 0;
        illegal_seen   = 0;
        resetn         = 1'b0;
        id_i           = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        repeat (4) begin    // idle after reset
            @(negedge clk);
            check_value("stall_o", stall_o, 0);
            check_value("rf_we_o", rf_we_o, 0);
            check_value("illegal_o", illegal_o, 0);
        end
        // fill the tested region with known words
        for (int w = 0; w < MEM_WORDS; w++) begin
            ins           = '0;
            ins.valid     = 1'b1;
            ins.alu_op    = ALU_ADD;
            ins.rs1       = w * 4;
            ins.dmem_type = DMEM_SW;
            ins.result_src = 4'b0001;
            ins.store_data = $random(seed);
            send_instr(ins);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            make_instr(ins);
            send_instr(ins);
        end
        ins = '0;
        while (exp_q.size() != 0) send_instr(ins);    // drain with bubbles
        repeat (DMEM_WAIT + 4) send_instr(ins);       // catch late extras
        check_value("illegal_o pulses", illegal_seen, illegal_exp);
        error_count += uut.u_chk.assert_errors;
        $display("closing: %0d errors, %0d writes checked, %0d illegal flags",
                 error_count, writes_checked, illegal_seen);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: backend_top.f
hdl/backend_pkg.sv
hdl/exe_stage.sv
hdl/wait_timer.sv
hdl/mem_access_fsm.sv
hdl/dmem_ram.sv
hdl/wb_stage.sv
hdl/backend_top.sv
verif/backend_checker.sv
verif/tb_backend_top.sv

// File: Bender.yml
package:
  name: backend_top

sources:
  - hdl/backend_pkg.sv
  - hdl/exe_stage.sv
  - hdl/wait_timer.sv
  - hdl/mem_access_fsm.sv
  - hdl/dmem_ram.sv
  - hdl/wb_stage.sv
  - hdl/backend_top.sv
  - target: simulation
    files:
      - verif/backend_checker.sv
      - verif/tb_backend_top.sv
